// ==== src/mix_defs.svh ====
// **********************************************************************
// MIX word geometry macros
// byte width, byte count and magnitude width
// **********************************************************************
`ifndef MIX_DEFS_SVH
`define MIX_DEFS_SVH

// one MIX byte holds 64 values
`define MIX_BYTE_BITS 6

// bytes per word, sign not counted
`define MIX_BYTES 5

// magnitude part of a word
`define MIX_MAG_BITS 30

`endif

// ==== src/mix_word_pkg.sv ====
// **********************************************************************
// MIX word formats
// data view, instruction view and the union of both
// **********************************************************************
`include "mix_defs.svh"

package mix_word_pkg;

	// data view, b[1] is the most significant byte as in Knuth
	typedef struct packed {
		logic                                       sign; // 1 = minus
		logic [1:`MIX_BYTES][`MIX_BYTE_BITS-1:0]    b;
	} mix_data_t;

	// instruction view, +AA I F C
	typedef struct packed {
		logic                           sign;
		logic [1:0][`MIX_BYTE_BITS-1:0] aa;   // address, unused by this core
		logic [`MIX_BYTE_BITS-1:0]      i;    // index spec, unused here
		logic [`MIX_BYTE_BITS-1:0]      f;    // field spec 8*L+R
		logic [`MIX_BYTE_BITS-1:0]      c;    // opcode
	} mix_instr_t;

	// same 31 bits, read either way
	typedef union packed {
		mix_data_t  data;
		mix_instr_t instr;
	} mix_word_u;

endpackage

// ==== src/mix_arith_pkg.sv ====
// **********************************************************************
// arithmetic core types
// opcodes, comparison indicator, request and response
// **********************************************************************
`include "mix_defs.svh"

package mix_arith_pkg;

	// only the opcodes this core executes
	typedef enum logic [`MIX_BYTE_BITS-1:0] {
		OP_ADD  = 6'd1,
		OP_SUB  = 6'd2,
		OP_CMPA = 6'd56
	} mix_op_e;

	// comparison indicator
	typedef enum logic [1:0] {
		CMP_LESS    = 2'd0,
		CMP_EQUAL   = 2'd1,
		CMP_GREATER = 2'd2
	} mix_cmp_e;

	// one request from the caller
	typedef struct packed {
		mix_word_pkg::mix_word_u instr; // decoded as instruction
		mix_word_pkg::mix_data_t ra;    // current rA
		mix_word_pkg::mix_data_t mem;   // contents of M
	} mix_req_t;

	// one response back to the caller
	typedef struct packed {
		mix_word_pkg::mix_data_t ra;       // new rA
		logic                    overflow; // magnitude carried out
		mix_cmp_e                cmp;      // only meaningful for CMPA
		logic                    err;      // bad F or unknown C
	} mix_rsp_t;

	// note: the caller keeps rA, nothing here is architectural state

endpackage

// ==== src/mix_field_select.sv ====
// **********************************************************************
// field selector
// picks bytes L..R of a word and right-aligns them
// **********************************************************************
`timescale 1ns/100ps
`include "mix_defs.svh"

module mix_field_select (
	input  mix_word_pkg::mix_data_t word,
	input  logic [2:0]              l,     // leftmost byte, 0 means sign
	input  logic [2:0]              r,     // rightmost byte
	output mix_word_pkg::mix_data_t field
);

	logic [1:`MIX_BYTES][`MIX_BYTE_BITS-1:0] masked; // bytes outside L..R zeroed

	always_comb begin
		int lo;
		int shamt;
		masked = '0;
		lo = (l == 3'd0) ? 1 : int'(l); // byte 0 is the sign, not a data byte
		for (int k = 1; k <= `MIX_BYTES; k++) begin
			if (k >= lo && k <= int'(r))
				masked[k] = word.b[k];
		end
		// move byte R down to byte 5
		shamt = `MIX_BYTE_BITS * (`MIX_BYTES - int'(r));
		field.b = masked >> shamt;
		// sign only taken when the field starts at 0
		field.sign = (l == 3'd0) ? word.sign : 1'b0;
	end

endmodule

// ==== src/mix_add.sv ====
// **********************************************************************
// two-cycle sign-magnitude adder / subtractor
// overflow is the carry out of the magnitude
// **********************************************************************
`timescale 1ns/100ps
`include "mix_defs.svh"

module mix_add (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    start,    // one-cycle pulse
	input  logic                    subtract, // negate in2 first
	input  mix_word_pkg::mix_data_t in1,      // sampled at start
	input  mix_word_pkg::mix_data_t in2,      // sampled one cycle later
	output logic                    stop,
	output mix_word_pkg::mix_data_t out,
	output logic                    overflow
);

	mix_word_pkg::mix_data_t  a_q;   // cached first summand
	logic                     sub_q;
	logic                     b_sign;
	logic [`MIX_MAG_BITS:0]   sum;   // |a|+|b|
	logic [`MIX_MAG_BITS:0]   d1;    // |a|-|b|
	logic [`MIX_MAG_BITS:0]   d2;    // |b|-|a|

	// stop follows start by one edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			stop <= 1'b0;
		else
			stop <= start;
	end

	always_ff @(posedge clk) begin
		if (start) begin
			a_q   <= in1;
			sub_q <= subtract;
		end
	end

	assign b_sign = sub_q ^ in2.sign; // subtraction is addition of -in2

	assign sum = {1'b0, a_q.b} + {1'b0, in2.b};
	assign d1  = {1'b0, a_q.b} - {1'b0, in2.b};
	assign d2  = {1'b0, in2.b} - {1'b0, a_q.b};

	// choose by the two signs
	always_comb begin
		if (a_q.sign == b_sign) begin
			out.sign = a_q.sign;               // same signs just add
			out.b    = sum[`MIX_MAG_BITS-1:0];
			overflow = sum[`MIX_MAG_BITS];
		end else if (!d1[`MIX_MAG_BITS]) begin
			out.sign = a_q.sign;               // |a| >= |b|, zero keeps a's sign
			out.b    = d1[`MIX_MAG_BITS-1:0];
			overflow = 1'b0;
		end else begin
			out.sign = b_sign;                 // |b| wins
			out.b    = d2[`MIX_MAG_BITS-1:0];
			overflow = 1'b0;
		end
	end

	// sequencer must never start back to back
	a_stop_single: assert property (@(posedge clk) disable iff (!rst_n)
		stop |=> !stop);

endmodule

// ==== src/mix_compare.sv ====
// **********************************************************************
// two-cycle sign-magnitude comparator
// +0 and -0 compare equal
// **********************************************************************
`timescale 1ns/100ps
`include "mix_defs.svh"

module mix_compare (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  mix_word_pkg::mix_data_t  in1, // sampled at start
	input  mix_word_pkg::mix_data_t  in2, // sampled one cycle later
	output logic                     stop,
	output mix_arith_pkg::mix_cmp_e  result
);

	mix_word_pkg::mix_data_t       a_q;
	logic signed [`MIX_MAG_BITS:0] va;  // two's complement of a_q
	logic signed [`MIX_MAG_BITS:0] vb;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			stop <= 1'b0;
		else
			stop <= start;
	end

	always_ff @(posedge clk) begin
		if (start)
			a_q <= in1;
	end

	// negating zero gives zero, so -0 == +0 for free
	assign va = a_q.sign ? -$signed({1'b0, a_q.b}) : $signed({1'b0, a_q.b});
	assign vb = in2.sign ? -$signed({1'b0, in2.b}) : $signed({1'b0, in2.b});

	always_comb begin
		if (va < vb)
			result = mix_arith_pkg::CMP_LESS;
		else if (va > vb)
			result = mix_arith_pkg::CMP_GREATER;
		else
			result = mix_arith_pkg::CMP_EQUAL;
	end

	a_stop_single: assert property (@(posedge clk) disable iff (!rst_n)
		stop |=> !stop);

endmodule

// ==== src/mix_arith_seq.sv ====
// **********************************************************************
// request sequencer
// decodes C and F, starts a unit, holds the response
// **********************************************************************
`timescale 1ns/100ps
`include "mix_defs.svh"

module mix_arith_seq (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     req_valid,
	output logic                     req_ready,
	input  mix_arith_pkg::mix_req_t  req,
	output logic                     rsp_valid,
	input  logic                     rsp_ready,
	output mix_arith_pkg::mix_rsp_t  rsp,
	output logic [2:0]               l,          // to both selectors
	output logic [2:0]               r,
	output logic                     start_add,
	output logic                     start_cmp,
	output logic                     subtract,
	output mix_word_pkg::mix_data_t  ra_op,
	output mix_word_pkg::mix_data_t  mem_op,
	input  logic                     add_stop,
	input  mix_word_pkg::mix_data_t  add_sum,
	input  logic                     add_ovf,
	input  logic                     cmp_stop,
	input  mix_arith_pkg::mix_cmp_e  cmp_result
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_BUSY,    // unit running or error pending
		S_RESPOND
	} state_e;

	state_e                   state;
	mix_arith_pkg::mix_req_t  req_q;     // operands stay here for the whole op
	mix_arith_pkg::mix_rsp_t  rsp_q;
	logic                     err_q;
	mix_word_pkg::mix_instr_t in_instr;  // incoming request in instruction view
	mix_word_pkg::mix_instr_t cur_instr; // latched request
	logic [2:0]               in_l;
	logic [2:0]               in_r;
	logic                     f_ok;
	logic                     is_add;
	logic                     is_cmp;
	logic                     accept;

	// decode the incoming word at the accepting edge
	assign in_instr = req.instr.instr;
	assign in_l     = in_instr.f[5:3];  // F/8
	assign in_r     = in_instr.f[2:0];  // F mod 8
	assign f_ok     = (in_l <= in_r) && (in_r <= 3'(`MIX_BYTES));
	assign is_add   = (in_instr.c == mix_arith_pkg::OP_ADD) ||
	                  (in_instr.c == mix_arith_pkg::OP_SUB);
	assign is_cmp   = in_instr.c == mix_arith_pkg::OP_CMPA;
	assign accept   = req_valid && req_ready;

	// unit side comes from the held request
	assign cur_instr = req_q.instr.instr;
	assign l         = cur_instr.f[5:3];
	assign r         = cur_instr.f[2:0];
	assign subtract  = cur_instr.c == mix_arith_pkg::OP_SUB;
	assign ra_op     = req_q.ra;
	assign mem_op    = req_q.mem;

	assign req_ready = state == S_IDLE;
	assign rsp_valid = state == S_RESPOND;
	assign rsp       = rsp_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			start_add <= 1'b0;
			start_cmp <= 1'b0;
			err_q     <= 1'b0;
		end else begin
			// one-cycle pulses high only after the accepting edge
			start_add <= accept && f_ok && is_add;
			start_cmp <= accept && f_ok && is_cmp;
			case (state)
				S_IDLE: begin
					if (accept) begin
						state <= S_BUSY;
						err_q <= !(f_ok && (is_add || is_cmp));
					end
				end
				S_BUSY: begin
					if (err_q || add_stop || cmp_stop)
						state <= S_RESPOND; // error skips the units and is one edge early
				end
				S_RESPOND: begin
					if (rsp_ready)
						state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			req_q <= req;
		if (state == S_BUSY) begin
			if (err_q)
				rsp_q <= '{ra: req_q.ra, overflow: 1'b0,
				           cmp: mix_arith_pkg::CMP_EQUAL, err: 1'b1};
			else if (add_stop)
				rsp_q <= '{ra: add_sum, overflow: add_ovf,
				           cmp: mix_arith_pkg::CMP_EQUAL, err: 1'b0};
			else if (cmp_stop)
				rsp_q <= '{ra: req_q.ra, overflow: 1'b0,  // CMPA leaves rA alone
				           cmp: cmp_result, err: 1'b0};
		end
	end

	// held response must not move under back-pressure
	a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

	// a unit answers alone and only while a good op waits for it
	a_one_unit: assert property (@(posedge clk) disable iff (!rst_n)
		add_stop || cmp_stop |-> state == S_BUSY && !err_q && !(add_stop && cmp_stop));

endmodule

// ==== src/mix_arith_unit.sv ====
// **********************************************************************
// MIX arithmetic core top level
// sequencer, two field selectors, adder and comparator
// **********************************************************************
`timescale 1ns/100ps

module mix_arith_unit (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    req_valid,
	output logic                    req_ready,
	input  mix_arith_pkg::mix_req_t req,
	output logic                    rsp_valid,
	input  logic                    rsp_ready,
	output mix_arith_pkg::mix_rsp_t rsp
);

	logic [2:0]               l;
	logic [2:0]               r;
	logic                     start_add;
	logic                     start_cmp;
	logic                     subtract;
	mix_word_pkg::mix_data_t  ra_op;
	mix_word_pkg::mix_data_t  mem_op;
	mix_word_pkg::mix_data_t  ra_field;   // rA(F), compare only
	mix_word_pkg::mix_data_t  mem_field;  // V = M(F)
	logic                     add_stop;
	mix_word_pkg::mix_data_t  add_sum;
	logic                     add_ovf;
	logic                     cmp_stop;
	mix_arith_pkg::mix_cmp_e  cmp_result;

	mix_arith_seq u_seq (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req        (req),
		.rsp_valid  (rsp_valid),
		.rsp_ready  (rsp_ready),
		.rsp        (rsp),
		.l          (l),
		.r          (r),
		.start_add  (start_add),
		.start_cmp  (start_cmp),
		.subtract   (subtract),
		.ra_op      (ra_op),
		.mem_op     (mem_op),
		.add_stop   (add_stop),
		.add_sum    (add_sum),
		.add_ovf    (add_ovf),
		.cmp_stop   (cmp_stop),
		.cmp_result (cmp_result)
	);

	mix_field_select u_sel_mem (
		.word  (mem_op),
		.l     (l),
		.r     (r),
		.field (mem_field)
	);

	mix_field_select u_sel_ra (
		.word  (ra_op),
		.l     (l),
		.r     (r),
		.field (ra_field)
	);

	// ADD/SUB use the whole rA against the field of M
	mix_add u_add (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start_add),
		.subtract (subtract),
		.in1      (ra_op),
		.in2      (mem_field),
		.stop     (add_stop),
		.out      (add_sum),
		.overflow (add_ovf)
	);

	mix_compare u_cmp (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start_cmp),
		.in1    (ra_field),
		.in2    (mem_field),
		.stop   (cmp_stop),
		.result (cmp_result)
	);

endmodule

// ==== tb/tb_clock.sv ====
// **********************************************************************
// testbench clock and reset generator
// 40 ns clock, reset held low for the first 10 cycles
// **********************************************************************
`timescale 1ns/100ps

module tb_clock #(
	parameter int PERIOD     = 40,
	parameter int RST_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#2 rst_n = 1'b1; // release away from the edge
	end

endmodule

// ==== tb/tb_mix_arith.sv ====
// **********************************************************************
// testbench for the MIX arithmetic core
// random and directed ADD/SUB/CMPA requests, reference model,
// concurrent assertions on value, latency and back-pressure
// **********************************************************************
`timescale 1ns/100ps

module tb_mix_arith;

	logic                     clk;
	logic                     rst_n;
	logic                     req_valid;
	logic                     req_ready;
	mix_arith_pkg::mix_req_t  req;
	logic                     rsp_valid;
	logic                     rsp_ready;
	mix_arith_pkg::mix_rsp_t  rsp;

	integer                   seed = 32'h4990;
	logic                     stall;     // response side held off next cycle
	string                    test_name;
	mix_arith_pkg::mix_rsp_t  exp_q[$];  // one entry per accepted request
	mix_arith_pkg::mix_rsp_t  exp_front; // oldest outstanding response
	mix_arith_pkg::mix_rsp_t  in_exp;    // model of the request on the bus
	int                       exp_cnt;
	int                       f_valid [9] = '{5, 0, 11, 37, 13, 45, 9, 2, 19};
	int                       f_bad [5]   = '{42, 6, 63, 23, 33}; // L>R or R>5

	tb_clock u_clock (.clk(clk), .rst_n(rst_n));

	mix_arith_unit u_mix_arith_unit (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req       (req),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp       (rsp)
	);

	// signed value of bytes L..R with the sign only when L is 0
	function automatic longint field_value(mix_word_pkg::mix_data_t w, int l, int r);
		longint m;
		m = 0;
		for (int k = (l == 0) ? 1 : l; k <= r; k++)
			m = m * 64 + longint'(w.b[k]);
		return (l == 0 && w.sign) ? -m : m;
	endfunction

	function automatic mix_arith_pkg::mix_rsp_t model_rsp(mix_arith_pkg::mix_req_t rq);
		mix_arith_pkg::mix_rsp_t e;
		int     c;
		int     l;
		int     r;
		longint v;
		longint fa;
		longint s;
		longint mag;
		e.ra       = rq.ra;           // default is rA untouched
		e.overflow = 1'b0;
		e.cmp      = mix_arith_pkg::CMP_EQUAL;
		e.err      = 1'b0;
		c = int'(rq.instr.instr.c);
		l = int'(rq.instr.instr.f) / 8;
		r = int'(rq.instr.instr.f) % 8;
		if (l > r || r > 5 || !(c == 1 || c == 2 || c == 56)) begin
			e.err = 1'b1;
			return e;
		end
		v = field_value(rq.mem, l, r);
		if (c == 56) begin
			fa = field_value(rq.ra, l, r); // -0 and +0 both give 0
			if (fa < v)
				e.cmp = mix_arith_pkg::CMP_LESS;
			else if (fa > v)
				e.cmp = mix_arith_pkg::CMP_GREATER;
			return e;
		end
		if (c == 2)
			v = -v;
		s   = field_value(rq.ra, 0, 5) + v;
		mag = (s < 0) ? -s : s;
		e.overflow = mag >= (64'sd1 <<< 30);
		e.ra.sign  = (s == 0) ? rq.ra.sign : (s < 0); // zero keeps rA sign
		e.ra.b     = mag[29:0];                       // low 30 bits on overflow
		return e;
	endfunction

	function mix_word_pkg::mix_data_t rand_word();
		mix_word_pkg::mix_data_t w;
		w.sign = 1'($random(seed));
		w.b    = 30'($random(seed));
		return w;
	endfunction

	function mix_word_pkg::mix_data_t mk_word(logic s, logic [29:0] m);
		mix_word_pkg::mix_data_t w;
		w.sign = s;
		w.b    = m;
		return w;
	endfunction

	function int pick(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic mix_arith_pkg::mix_req_t make_req(int op, int f,
			mix_word_pkg::mix_data_t ra, mix_word_pkg::mix_data_t mem);
		mix_arith_pkg::mix_req_t rq;
		rq = '0;
		rq.instr.instr.c = 6'(op);
		rq.instr.instr.f = 6'(f);
		rq.ra  = ra;
		rq.mem = mem;
		return rq;
	endfunction

	assign in_exp = model_rsp(req);

	// reference queue pushed at accept and popped at transfer
	always @(posedge clk) begin
		if (rst_n) begin
			if (req_valid && req_ready)
				exp_q.push_back(in_exp);
			if (rsp_valid && rsp_ready)
				void'(exp_q.pop_front());
		end
		exp_front <= (exp_q.size() > 0) ? exp_q[0] : '0;
		exp_cnt   <= exp_q.size();
	end

	// random stalls on the response side, drawn at the edge
	always @(posedge clk) begin
		stall = ($random(seed) & 3) == 0; // about one cycle in four
		#2 rsp_ready = !stall;
	end

	a_rsp_value: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && rsp_ready |-> rsp == exp_front)
	else begin
		$display("mismatch %s expected %h actual %h", test_name,
			$sampled(exp_front), $sampled(rsp));
		$display("TEST RESULT: FAIL");
		$fatal(1, "wrong response");
	end

	// a transfer with nothing outstanding is a duplicate
	a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && rsp_ready |-> exp_cnt > 0)
	else begin
		$display("response delivered with no request outstanding in %s", test_name);
		$display("TEST RESULT: FAIL");
		$fatal(1, "duplicate response");
	end

	a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
	else begin
		$display("response changed or dropped while stalled in %s", test_name);
		$display("TEST RESULT: FAIL");
		$fatal(1, "unstable response");
	end

	a_lat_arith: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid && req_ready && !in_exp.err |-> ##1 !rsp_valid ##1 !rsp_valid ##1 rsp_valid)
	else begin
		$display("arithmetic response not two edges after accept in %s", test_name);
		$display("TEST RESULT: FAIL");
		$fatal(1, "latency");
	end

	a_lat_err: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid && req_ready && in_exp.err |-> ##1 !rsp_valid ##1 rsp_valid)
	else begin
		$display("error response not one edge after accept in %s", test_name);
		$display("TEST RESULT: FAIL");
		$fatal(1, "latency");
	end

	task automatic wait_reset();
		int waited;
		waited = 0;
		while (!rst_n) begin
			@(posedge clk);
			waited++;
			if (waited > 20) begin
				$display("reset never released");
				$display("TEST RESULT: FAIL");
				$fatal(1, "timeout");
			end
		end
		@(posedge clk);
		#2;
	endtask

	// entered and left 2 ns after a rising edge
	task automatic send_req(mix_arith_pkg::mix_req_t rq);
		int waited;
		waited    = 0;
		req       = rq;
		req_valid = 1'b1;
		while (!req_ready) begin
			@(posedge clk);
			#2;
			waited++;
			if (waited > 20) begin
				$display("timeout waiting for req_ready in %s", test_name);
				$display("TEST RESULT: FAIL");
				$fatal(1, "timeout");
			end
		end
		@(posedge clk); // transfer edge
		#2;
		req_valid = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 || rsp_valid) begin
			@(posedge clk);
			#2;
			waited++;
			if (waited > 20) begin
				$display("timeout waiting for rsp_valid in %s, response lost", test_name);
				$display("TEST RESULT: FAIL");
				$fatal(1, "timeout");
			end
		end
	endtask

	initial begin
		logic [29:0] max_mag;
		int          op;
		max_mag   = 30'h3fff_ffff;
		req_valid = 1'b0;
		req       = '0;
		rsp_ready = 1'b0;
		test_name = "reset";
		wait_reset();
		assert (req_ready && !rsp_valid)
		else begin
			$display("req_ready low or rsp_valid high after reset");
			$display("TEST RESULT: FAIL");
			$fatal(1, "reset state");
		end

		test_name = "add_sub_full";
		for (int i = 0; i < 30; i++)
			send_req(make_req(1 + pick(2), 5, rand_word(), rand_word()));
		send_req(make_req(1, 5, mk_word(1'b1, 30'd7), mk_word(1'b0, 30'd7))); // gives -0
		send_req(make_req(2, 5, mk_word(1'b0, 30'd7), mk_word(1'b0, 30'd7))); // gives +0
		send_req(make_req(1, 5, mk_word(1'b1, 30'd0), mk_word(1'b0, 30'd0)));
		wait_drain();

		test_name = "overflow";
		send_req(make_req(1, 5, mk_word(1'b0, max_mag), mk_word(1'b0, 30'd1)));
		send_req(make_req(2, 5, mk_word(1'b1, max_mag), mk_word(1'b0, 30'd5)));
		for (int i = 0; i < 10; i++)
			send_req(make_req(1, 5, mk_word(1'b1, {1'b1, 29'($random(seed))}),
				mk_word(1'b1, {1'b1, 29'($random(seed))})));
		wait_drain();

		test_name = "partial_field";
		for (int i = 0; i < 30; i++)
			send_req(make_req(1 + pick(2), f_valid[pick(9)], rand_word(), rand_word()));
		wait_drain();

		test_name = "cmpa";
		for (int i = 0; i < 30; i++)
			send_req(make_req(56, f_valid[pick(9)], rand_word(), rand_word()));
		send_req(make_req(56, 5, mk_word(1'b0, 30'd0), mk_word(1'b1, 30'd0))); // +0 vs -0
		send_req(make_req(56, 0, mk_word(1'b1, 30'd3), mk_word(1'b0, 30'd9))); // signs only
		send_req(make_req(56, 5, mk_word(1'b1, 30'd42), mk_word(1'b1, 30'd42)));
		wait_drain();

		test_name = "invalid";
		for (int i = 0; i < 5; i++)
			send_req(make_req(1 + pick(2), f_bad[i], rand_word(), rand_word()));
		send_req(make_req(56, 42, rand_word(), rand_word()));
		send_req(make_req(0, 5, rand_word(), rand_word()));
		send_req(make_req(3, 5, rand_word(), rand_word()));
		send_req(make_req(63, 0, rand_word(), rand_word()));
		wait_drain();

		// back-to-back mix of everything under random stalls
		test_name = "handshake";
		for (int i = 0; i < 40; i++) begin
			case (pick(10))
				0, 1, 2, 3: op = 1;
				4, 5, 6:    op = 2;
				7, 8:       op = 56;
				default:    op = 8;  // not an arithmetic opcode
			endcase
			if (pick(5) == 0)
				send_req(make_req(op, f_bad[pick(5)], rand_word(), rand_word()));
			else
				send_req(make_req(op, f_valid[pick(9)], rand_word(), rand_word()));
		end
		wait_drain();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+src
src/mix_word_pkg.sv
src/mix_arith_pkg.sv
src/mix_field_select.sv
src/mix_add.sv
src/mix_compare.sv
src/mix_arith_seq.sv
src/mix_arith_unit.sv
tb/tb_clock.sv
tb/tb_mix_arith.sv

// ==== run.sh ====
#!/bin/sh
# build and run the MIX arithmetic core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_mix_arith -o tb_mix_arith

# the log decides pass or fail, not the exit status of the run
./obj_dir/tb_mix_arith 2>&1 | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	exit 0
else
	exit 1
fi
